// ==== include/udp_demux_config.svh ====
/*
 * UDP demultiplexer configuration
 * Output count, select width and payload width shared by the
 * package types and the testbench.
 */

`ifndef UDP_DEMUX_CONFIG_SVH
`define UDP_DEMUX_CONFIG_SVH

// number of frame outputs
`define UDP_DEMUX_OUTPUTS 4

// width of the output select, log2 of the output count
`define UDP_DEMUX_SEL_W 2

// payload beat width in bits
`define UDP_DEMUX_DATA_W 8

`endif

// ==== logic/udp_demux_pkg.sv ====
/*
 * UDP demultiplexer types
 * Header field types, per-output masks and the route state machine.
 */

`include "udp_demux_config.svh"

package udp_demux_pkg;

    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;
    typedef logic [15:0] udp_len_t;
    typedef logic [15:0] udp_csum_t;

    typedef logic [`UDP_DEMUX_DATA_W-1:0]  payload_t;
    typedef logic [`UDP_DEMUX_SEL_W-1:0]   port_sel_t;
    // one bit per output
    typedef logic [`UDP_DEMUX_OUTPUTS-1:0] port_mask_t;

    typedef enum logic {ROUTE_IDLE, ROUTE_FRAME} route_state_t;

endpackage

// ==== logic/udp_route_ctrl.sv ====
`timescale 1ns/10ps

/*
 * UDP route controller
 * Opens a frame when a header arrives and the requested output is free,
 * latches the output select and the header fields, and raises the header
 * valid of the chosen output. The frame closes on the accepted tlast beat.
 */
module udp_route_ctrl (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      enable,
    input  udp_demux_pkg::port_sel_t  sel,

    input  logic                      in_hdr_valid,
    output logic                      in_hdr_ready,
    input  udp_demux_pkg::ip_addr_t   in_ip_dest_ip,
    input  udp_demux_pkg::udp_port_t  in_udp_source_port,
    input  udp_demux_pkg::udp_port_t  in_udp_dest_port,
    input  udp_demux_pkg::udp_len_t   in_udp_length,
    input  udp_demux_pkg::udp_csum_t  in_udp_checksum,

    input  logic                      in_payload_tvalid,
    input  logic                      in_payload_tready,
    input  logic                      in_payload_tlast,

    output udp_demux_pkg::port_mask_t out_hdr_valid,
    input  udp_demux_pkg::port_mask_t out_hdr_ready,
    output udp_demux_pkg::ip_addr_t   out_ip_dest_ip,
    output udp_demux_pkg::udp_port_t  out_udp_source_port,
    output udp_demux_pkg::udp_port_t  out_udp_dest_port,
    output udp_demux_pkg::udp_len_t   out_udp_length,
    output udp_demux_pkg::udp_csum_t  out_udp_checksum,

    input  udp_demux_pkg::port_mask_t out_payload_tvalid,

    output udp_demux_pkg::port_sel_t  route_sel,
    output logic                      frame_open
);

    udp_demux_pkg::route_state_t state;
    udp_demux_pkg::route_state_t state_next;
    logic start;
    logic frame_end;
    logic hdr_busy;
    logic payload_busy;

    // the header field registers are shared, so any pending header
    // holds off the next frame
    assign hdr_busy = |out_hdr_valid;
    // a beat still waiting on the requested output
    assign payload_busy = out_payload_tvalid[sel];

    assign start = (state == udp_demux_pkg::ROUTE_IDLE) && enable && in_hdr_valid &&
                   !hdr_busy && !payload_busy;

    assign frame_end = in_payload_tvalid && in_payload_tready && in_payload_tlast;

    always_comb begin
        state_next = state;
        case (state)
            udp_demux_pkg::ROUTE_IDLE: begin
                if (start) begin
                    state_next = udp_demux_pkg::ROUTE_FRAME;
                end
            end
            udp_demux_pkg::ROUTE_FRAME: begin
                if (frame_end) begin
                    state_next = udp_demux_pkg::ROUTE_IDLE;
                end
            end
            default: begin
                state_next = udp_demux_pkg::ROUTE_IDLE;
            end
        endcase
    end

    // next-cycle frame state, lets the payload ready register track it
    assign frame_open = (state_next == udp_demux_pkg::ROUTE_FRAME);

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= udp_demux_pkg::ROUTE_IDLE;
            route_sel     <= '0;
            in_hdr_ready  <= 1'b0;
            out_hdr_valid <= '0;
        end else begin
            state        <= state_next;
            // one-cycle pulse, start cannot repeat while the frame is open
            in_hdr_ready <= start;
            if (start) begin
                route_sel     <= sel;
                out_hdr_valid <= (out_hdr_valid & ~out_hdr_ready) |
                                 (udp_demux_pkg::port_mask_t'(1) << sel);
            end else begin
                out_hdr_valid <= out_hdr_valid & ~out_hdr_ready;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            out_ip_dest_ip      <= in_ip_dest_ip;
            out_udp_source_port <= in_udp_source_port;
            out_udp_dest_port   <= in_udp_dest_port;
            out_udp_length      <= in_udp_length;
            out_udp_checksum    <= in_udp_checksum;
        end
    end

    // a header is never offered on two outputs at once
    assert property (@(posedge clk) disable iff (rst) $onehot0(out_hdr_valid))
        else $error("header valid set on more than one output");

endmodule

// ==== logic/udp_payload_demux.sv ====
`timescale 1ns/10ps

/*
 * UDP payload demultiplexer
 * Two-entry skid buffer with a registered input ready. Each beat is
 * steered to the output given by route_sel through a one-hot valid mask.
 */
module udp_payload_demux (
    input  logic                      clk,
    input  logic                      rst,
    input  udp_demux_pkg::port_sel_t  route_sel,
    input  logic                      frame_open,

    input  udp_demux_pkg::payload_t   in_payload_tdata,
    input  logic                      in_payload_tvalid,
    output logic                      in_payload_tready,
    input  logic                      in_payload_tlast,
    input  logic                      in_payload_tuser,

    output udp_demux_pkg::payload_t   out_payload_tdata,
    output udp_demux_pkg::port_mask_t out_payload_tvalid,
    input  udp_demux_pkg::port_mask_t out_payload_tready,
    output logic                      out_payload_tlast,
    output logic                      out_payload_tuser
);

    logic                      ready_int;
    logic                      ready_early;
    logic                      beat_valid;
    logic                      held_valid;
    logic                      held_ready;
    udp_demux_pkg::port_mask_t tvalid_next;

    udp_demux_pkg::payload_t   temp_tdata;
    logic                      temp_tlast;
    logic                      temp_tuser;
    logic                      temp_valid;
    logic                      temp_valid_next;
    udp_demux_pkg::port_sel_t  temp_sel;

    logic int_to_out;
    logic int_to_temp;
    logic temp_to_out;

    assign beat_valid = in_payload_tvalid && in_payload_tready;

    // the held beat may belong to the previous frame, so its own output
    // decides when it drains
    assign held_valid = |out_payload_tvalid;
    assign held_ready = |(out_payload_tvalid & out_payload_tready);

    // ready next cycle unless the temp register would have to fill
    assign ready_early = held_ready || (!temp_valid && (!held_valid || !beat_valid));

    always_comb begin
        tvalid_next     = out_payload_tvalid;
        temp_valid_next = temp_valid;
        int_to_out      = 1'b0;
        int_to_temp     = 1'b0;
        temp_to_out     = 1'b0;

        if (ready_int) begin
            if (held_ready || !held_valid) begin
                tvalid_next = beat_valid ? (udp_demux_pkg::port_mask_t'(1) << route_sel) : '0;
                int_to_out  = 1'b1;
            end else begin
                temp_valid_next = beat_valid;
                int_to_temp     = 1'b1;
            end
        end else if (held_ready) begin
            tvalid_next     = temp_valid ? (udp_demux_pkg::port_mask_t'(1) << temp_sel) : '0;
            temp_valid_next = 1'b0;
            temp_to_out     = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ready_int          <= 1'b0;
            in_payload_tready  <= 1'b0;
            out_payload_tvalid <= '0;
            temp_valid         <= 1'b0;
        end else begin
            ready_int          <= ready_early;
            in_payload_tready  <= ready_early && frame_open;
            out_payload_tvalid <= tvalid_next;
            temp_valid         <= temp_valid_next;
        end
    end

    always_ff @(posedge clk) begin
        if (int_to_out) begin
            out_payload_tdata <= in_payload_tdata;
            out_payload_tlast <= in_payload_tlast;
            out_payload_tuser <= in_payload_tuser;
        end else if (temp_to_out) begin
            out_payload_tdata <= temp_tdata;
            out_payload_tlast <= temp_tlast;
            out_payload_tuser <= temp_tuser;
        end
        if (int_to_temp) begin
            temp_tdata <= in_payload_tdata;
            temp_tlast <= in_payload_tlast;
            temp_tuser <= in_payload_tuser;
            temp_sel   <= route_sel;
        end
    end

    // temp only ever holds a beat queued behind an occupied output register
    assert property (@(posedge clk) disable iff (rst) temp_valid |-> held_valid)
        else $error("skid temp register valid with empty output stage");

    assert property (@(posedge clk) disable iff (rst) $onehot0(out_payload_tvalid))
        else $error("payload valid set on more than one output");

endmodule

// ==== logic/udp_demux.sv ====
`timescale 1ns/10ps

/*
 * UDP four-way frame demultiplexer
 * Routes each frame, header and payload, to the output picked by sel
 * at the start of the frame. New frames wait while enable is low.
 */
module udp_demux (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      enable,
    input  udp_demux_pkg::port_sel_t  sel,

    input  logic                      in_hdr_valid,
    output logic                      in_hdr_ready,
    input  udp_demux_pkg::ip_addr_t   in_ip_dest_ip,
    input  udp_demux_pkg::udp_port_t  in_udp_source_port,
    input  udp_demux_pkg::udp_port_t  in_udp_dest_port,
    input  udp_demux_pkg::udp_len_t   in_udp_length,
    input  udp_demux_pkg::udp_csum_t  in_udp_checksum,
    input  udp_demux_pkg::payload_t   in_payload_tdata,
    input  logic                      in_payload_tvalid,
    output logic                      in_payload_tready,
    input  logic                      in_payload_tlast,
    input  logic                      in_payload_tuser,

    output udp_demux_pkg::port_mask_t out_hdr_valid,
    input  udp_demux_pkg::port_mask_t out_hdr_ready,
    output udp_demux_pkg::ip_addr_t   out_ip_dest_ip,
    output udp_demux_pkg::udp_port_t  out_udp_source_port,
    output udp_demux_pkg::udp_port_t  out_udp_dest_port,
    output udp_demux_pkg::udp_len_t   out_udp_length,
    output udp_demux_pkg::udp_csum_t  out_udp_checksum,
    output udp_demux_pkg::payload_t   out_payload_tdata,
    output udp_demux_pkg::port_mask_t out_payload_tvalid,
    input  udp_demux_pkg::port_mask_t out_payload_tready,
    output logic                      out_payload_tlast,
    output logic                      out_payload_tuser
);

    udp_demux_pkg::port_sel_t route_sel;
    logic                     frame_open;

    udp_route_ctrl i_udp_route_ctrl (
        .clk                 (clk),
        .rst                 (rst),
        .enable              (enable),
        .sel                 (sel),
        .in_hdr_valid        (in_hdr_valid),
        .in_hdr_ready        (in_hdr_ready),
        .in_ip_dest_ip       (in_ip_dest_ip),
        .in_udp_source_port  (in_udp_source_port),
        .in_udp_dest_port    (in_udp_dest_port),
        .in_udp_length       (in_udp_length),
        .in_udp_checksum     (in_udp_checksum),
        .in_payload_tvalid   (in_payload_tvalid),
        .in_payload_tready   (in_payload_tready),
        .in_payload_tlast    (in_payload_tlast),
        .out_hdr_valid       (out_hdr_valid),
        .out_hdr_ready       (out_hdr_ready),
        .out_ip_dest_ip      (out_ip_dest_ip),
        .out_udp_source_port (out_udp_source_port),
        .out_udp_dest_port   (out_udp_dest_port),
        .out_udp_length      (out_udp_length),
        .out_udp_checksum    (out_udp_checksum),
        .out_payload_tvalid  (out_payload_tvalid),
        .route_sel           (route_sel),
        .frame_open          (frame_open)
    );

    udp_payload_demux i_udp_payload_demux (
        .clk                (clk),
        .rst                (rst),
        .route_sel          (route_sel),
        .frame_open         (frame_open),
        .in_payload_tdata   (in_payload_tdata),
        .in_payload_tvalid  (in_payload_tvalid),
        .in_payload_tready  (in_payload_tready),
        .in_payload_tlast   (in_payload_tlast),
        .in_payload_tuser   (in_payload_tuser),
        .out_payload_tdata  (out_payload_tdata),
        .out_payload_tvalid (out_payload_tvalid),
        .out_payload_tready (out_payload_tready),
        .out_payload_tlast  (out_payload_tlast),
        .out_payload_tuser  (out_payload_tuser)
    );

endmodule

// ==== dv/udp_demux_tb.sv ====
`timescale 1ns/10ps

/*
 * UDP demultiplexer testbench
 * Sends random frames with random output select, payload gaps, output
 * back-pressure and enable windows, and checks every header and payload
 * transfer against expected queues.
 */
module udp_demux_tb;

    localparam int NUM_FRAMES       = 200;
    localparam int CYCLES_PER_FRAME = 200;
    localparam int DRAIN_CYCLES     = 1000;

    logic clk = 1'b0;
    logic rst;
    logic enable;
    logic enable_seen;
    udp_demux_pkg::port_sel_t  sel;
    logic                      in_hdr_valid;
    logic                      in_hdr_ready;
    udp_demux_pkg::ip_addr_t   in_ip_dest_ip;
    udp_demux_pkg::udp_port_t  in_udp_source_port;
    udp_demux_pkg::udp_port_t  in_udp_dest_port;
    udp_demux_pkg::udp_len_t   in_udp_length;
    udp_demux_pkg::udp_csum_t  in_udp_checksum;
    udp_demux_pkg::payload_t   in_payload_tdata;
    logic                      in_payload_tvalid;
    logic                      in_payload_tready;
    logic                      in_payload_tlast;
    logic                      in_payload_tuser;
    udp_demux_pkg::port_mask_t out_hdr_valid;
    udp_demux_pkg::port_mask_t out_hdr_ready = '0;
    udp_demux_pkg::ip_addr_t   out_ip_dest_ip;
    udp_demux_pkg::udp_port_t  out_udp_source_port;
    udp_demux_pkg::udp_port_t  out_udp_dest_port;
    udp_demux_pkg::udp_len_t   out_udp_length;
    udp_demux_pkg::udp_csum_t  out_udp_checksum;
    udp_demux_pkg::payload_t   out_payload_tdata;
    udp_demux_pkg::port_mask_t out_payload_tvalid;
    udp_demux_pkg::port_mask_t out_payload_tready = '0;
    logic                      out_payload_tlast;
    logic                      out_payload_tuser;

    integer seed = 32'h193195f4;

    // frame on offer, fixed until its last byte is accepted
    udp_demux_pkg::port_sel_t  pend_sel;
    udp_demux_pkg::ip_addr_t   pend_dest_ip;
    udp_demux_pkg::udp_port_t  pend_src_port;
    udp_demux_pkg::udp_port_t  pend_dst_port;
    udp_demux_pkg::udp_len_t   pend_length;
    udp_demux_pkg::udp_csum_t  pend_csum;
    udp_demux_pkg::payload_t   pend_data [8];
    logic                      pend_user [8];
    int                        pend_len;

    // {sel, fields} and {sel, tlast, tuser, tdata}, in output order
    logic [97:0] hdr_q [$];
    logic [11:0] pay_q [$];

    udp_demux i_udp_demux (
        .clk                 (clk),
        .rst                 (rst),
        .enable              (enable),
        .sel                 (sel),
        .in_hdr_valid        (in_hdr_valid),
        .in_hdr_ready        (in_hdr_ready),
        .in_ip_dest_ip       (in_ip_dest_ip),
        .in_udp_source_port  (in_udp_source_port),
        .in_udp_dest_port    (in_udp_dest_port),
        .in_udp_length       (in_udp_length),
        .in_udp_checksum     (in_udp_checksum),
        .in_payload_tdata    (in_payload_tdata),
        .in_payload_tvalid   (in_payload_tvalid),
        .in_payload_tready   (in_payload_tready),
        .in_payload_tlast    (in_payload_tlast),
        .in_payload_tuser    (in_payload_tuser),
        .out_hdr_valid       (out_hdr_valid),
        .out_hdr_ready       (out_hdr_ready),
        .out_ip_dest_ip      (out_ip_dest_ip),
        .out_udp_source_port (out_udp_source_port),
        .out_udp_dest_port   (out_udp_dest_port),
        .out_udp_length      (out_udp_length),
        .out_udp_checksum    (out_udp_checksum),
        .out_payload_tdata   (out_payload_tdata),
        .out_payload_tvalid  (out_payload_tvalid),
        .out_payload_tready  (out_payload_tready),
        .out_payload_tlast   (out_payload_tlast),
        .out_payload_tuser   (out_payload_tuser)
    );

    always #10 clk = ~clk;

    // enable as seen by the controller at the last edge
    always @(posedge clk) enable_seen <= enable;

    function automatic logic [31:0] next_rand();
        next_rand = $random(seed);
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic compare_values(input logic [127:0] actual, input logic [127:0] expected,
                                  input string what);
        if (actual !== expected) begin
            abort_run($sformatf("FAILED at %0d ns: %s, got %0h, expected %0h",
                                $time, what, actual, expected));
        end
    endtask

    // output back-pressure, then the transfers that the next edge will see
    always @(negedge clk) begin : check_outputs
        logic [31:0] r;
        logic [97:0] exp_hdr;
        logic [11:0] exp_beat;
        int k;
        r = next_rand();
        out_payload_tready = r[3:0] | r[7:4];
        out_hdr_ready      = r[11:8] | r[15:12];
        if (!rst) begin
            if (in_hdr_ready) begin
                if (!enable_seen) begin
                    abort_run("a header was accepted while enable was low");
                end
                hdr_q.push_back({pend_sel, pend_dest_ip, pend_src_port, pend_dst_port,
                                 pend_length, pend_csum});
                for (k = 0; k < pend_len; k++) begin
                    pay_q.push_back({pend_sel, k == pend_len - 1, pend_user[k], pend_data[k]});
                end
            end
            if (out_hdr_valid != '0) begin
                if (hdr_q.size() == 0) begin
                    abort_run("a header valid was raised with no header expected");
                end else begin
                    exp_hdr = hdr_q[0];
                    compare_values(128'(out_hdr_valid), 128'(4'b0001 << exp_hdr[97:96]),
                                   "header valid mask");
                    if ((out_hdr_valid & out_hdr_ready) != '0) begin
                        compare_values(128'({out_ip_dest_ip, out_udp_source_port,
                                             out_udp_dest_port, out_udp_length,
                                             out_udp_checksum}),
                                       128'(exp_hdr[95:0]), "header fields");
                        hdr_q.delete(0);
                    end
                end
            end
            if (out_payload_tvalid != '0) begin
                if (pay_q.size() == 0) begin
                    abort_run("a payload valid was raised with no byte expected");
                end else begin
                    exp_beat = pay_q[0];
                    compare_values(128'(out_payload_tvalid), 128'(4'b0001 << exp_beat[11:10]),
                                   "payload valid mask");
                    if ((out_payload_tvalid & out_payload_tready) != '0) begin
                        compare_values(128'({out_payload_tlast, out_payload_tuser,
                                             out_payload_tdata}),
                                       128'(exp_beat[9:0]), "payload beat");
                        pay_q.delete(0);
                    end
                end
            end
        end
    end

    initial begin : enable_windows
        logic [31:0] r;
        enable = 1'b1;
        forever begin
            r = next_rand();
            repeat (8 + int'(r[5:0])) @(negedge clk);
            enable = 1'b0;
            repeat (1 + int'(r[9:6])) @(negedge clk);
            enable = 1'b1;
        end
    end

    initial begin : watchdog
        repeat (NUM_FRAMES * CYCLES_PER_FRAME) @(posedge clk);
        abort_run("timeout, the frames did not complete in the allowed number of cycles");
    end

    initial begin : drive_frames
        logic [31:0] r;
        int f;
        int i;
        rst                = 1'b1;
        sel                = '0;
        in_hdr_valid       = 1'b0;
        in_ip_dest_ip      = '0;
        in_udp_source_port = '0;
        in_udp_dest_port   = '0;
        in_udp_length      = '0;
        in_udp_checksum    = '0;
        in_payload_tdata   = '0;
        in_payload_tvalid  = 1'b0;
        in_payload_tlast   = 1'b0;
        in_payload_tuser   = 1'b0;
        pend_len           = 0;
        repeat (3) @(negedge clk);
        rst = 1'b0;
        repeat (8) begin
            @(negedge clk);
            compare_values(128'({in_hdr_ready, in_payload_tready, out_hdr_valid,
                                 out_payload_tvalid}), 128'(0), "idle outputs after reset");
        end
        for (f = 0; f < NUM_FRAMES; f++) begin
            r = next_rand();
            pend_sel     = r[1:0];
            pend_len     = 1 + int'(r[4:2]);
            pend_dest_ip = next_rand();
            r = next_rand();
            pend_src_port = r[15:0];
            pend_dst_port = r[31:16];
            r = next_rand();
            pend_length = r[15:0];
            pend_csum   = r[31:16];
            for (i = 0; i < pend_len; i++) begin
                r = next_rand();
                pend_data[i] = r[7:0];
                pend_user[i] = r[8];
            end
            // header held until the ready pulse
            sel                = pend_sel;
            in_ip_dest_ip      = pend_dest_ip;
            in_udp_source_port = pend_src_port;
            in_udp_dest_port   = pend_dst_port;
            in_udp_length      = pend_length;
            in_udp_checksum    = pend_csum;
            in_hdr_valid       = 1'b1;
            @(negedge clk);
            while (!in_hdr_ready) @(negedge clk);
            in_hdr_valid = 1'b0;
            for (i = 0; i < pend_len; i++) begin
                r = next_rand();
                in_payload_tvalid = 1'b0;
                if (r[2]) begin
                    repeat (1 + int'(r[1:0])) @(negedge clk);
                end
                in_payload_tdata  = pend_data[i];
                in_payload_tlast  = (i == pend_len - 1);
                in_payload_tuser  = pend_user[i];
                in_payload_tvalid = 1'b1;
                // tready is registered, so its value now is what the next edge sees
                while (!in_payload_tready) @(negedge clk);
                @(negedge clk);
            end
            in_payload_tvalid = 1'b0;
        end
        for (i = 0; i < DRAIN_CYCLES; i++) begin
            if (hdr_q.size() == 0 && pay_q.size() == 0) break;
            @(negedge clk);
        end
        if (hdr_q.size() == 0 && pay_q.size() == 0) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            abort_run("expected headers or bytes never appeared on the outputs");
        end
    end

endmodule

// ==== build.f ====
+incdir+include
logic/udp_demux_pkg.sv
logic/udp_route_ctrl.sv
logic/udp_payload_demux.sv
logic/udp_demux.sv
dv/udp_demux_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the UDP demultiplexer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module udp_demux_tb -f build.f \
    --Mdir obj_dir -o udp_demux_sim
./obj_dir/udp_demux_sim | tee sim.log

if grep -qx "Finished with no errors" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi
